//--- project.f
+incdir+logic
+incdir+tb
logic/vint_pkg.sv
logic/vint_decode.sv
logic/vint_simple_alu.sv
logic/vint_mul_pipe.sv
logic/vint_div_stage.sv
logic/vint_div_pipe.sv
logic/vint_lane_top.sv
tb/tb_vint_lane.sv

//--- tb/vint_ref_model.svh
// Expected results for the vector integer lane
// Unit lookup per opcode, plus ALU, multiply and divide results
`ifndef VINT_REF_MODEL_SVH
`define VINT_REF_MODEL_SVH

localparam int UNIT_ALU  = 0;
localparam int UNIT_MUL  = 1;
localparam int UNIT_DIV  = 2;
localparam int UNIT_NONE = 3;

function automatic int unit_of(input logic [2:0] f3, input logic [5:0] f6);
    logic opi;
    logic opm;
    opi = (f3 == vint_pkg::OPIVV) || (f3 == vint_pkg::OPIVX);
    opm = (f3 == vint_pkg::OPMVV) || (f3 == vint_pkg::OPMVX);
    if (opi) begin
        case (f6)
            vint_pkg::F6_VADD, vint_pkg::F6_VSUB, vint_pkg::F6_VRSUB,
            vint_pkg::F6_VAND, vint_pkg::F6_VOR, vint_pkg::F6_VXOR,
            vint_pkg::F6_VSLL_VMUL, vint_pkg::F6_VSRL, vint_pkg::F6_VSRA,
            vint_pkg::F6_VMINU, vint_pkg::F6_VMIN,
            vint_pkg::F6_VMAXU, vint_pkg::F6_VMAX: return UNIT_ALU;
            default: return UNIT_NONE;
        endcase
    end
    if (opm) begin
        case (f6)
            vint_pkg::F6_VSLL_VMUL, vint_pkg::F6_VMULH,
            vint_pkg::F6_VMULHSU, vint_pkg::F6_VMULHU: return UNIT_MUL;
            vint_pkg::F6_VDIVU, vint_pkg::F6_VDIV,
            vint_pkg::F6_VREMU, vint_pkg::F6_VREM: return UNIT_DIV;
            default: return UNIT_NONE;
        endcase
    end
    return UNIT_NONE;
endfunction

// Result is vs2 op vs1, with b as vs2
function automatic logic [31:0] ref_alu(input logic [5:0] f6, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [4:0]         sh;
    logic signed [63:0] wide;
    sh   = a[4:0];
    wide = $signed(b);
    case (f6)
        vint_pkg::F6_VADD:      return b + a;
        vint_pkg::F6_VSUB:      return b - a;
        vint_pkg::F6_VRSUB:     return a - b;
        vint_pkg::F6_VAND:      return a & b;
        vint_pkg::F6_VOR:       return a | b;
        vint_pkg::F6_VXOR:      return a ^ b;
        vint_pkg::F6_VSLL_VMUL: return b << sh;
        vint_pkg::F6_VSRL:      return b >> sh;
        vint_pkg::F6_VSRA:      return 32'(wide >>> sh);
        vint_pkg::F6_VMINU:     return (a < b) ? a : b;
        vint_pkg::F6_VMIN:      return ($signed(a) < $signed(b)) ? a : b;
        vint_pkg::F6_VMAXU:     return (a > b) ? a : b;
        default:                return ($signed(a) > $signed(b)) ? a : b;
    endcase
endfunction

// Operands are extended to 64 bits by their signedness, then multiplied
function automatic logic [31:0] ref_mul(input logic [5:0] f6, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] p;
    xa = {32'd0, a};
    xb = {32'd0, b};
    if (f6 == vint_pkg::F6_VMULH) begin
        xa = {{32{a[31]}}, a};
    end
    if (f6 == vint_pkg::F6_VMULH || f6 == vint_pkg::F6_VMULHSU) begin
        xb = {{32{b[31]}}, b};
    end
    p = xa * xb;
    return (f6 == vint_pkg::F6_VSLL_VMUL) ? p[31:0] : p[63:32];
endfunction

// 64-bit division truncates toward zero and gives the remainder the dividend sign
function automatic logic [31:0] ref_div(input logic [5:0] f6, input logic [31:0] a,
                                        input logic [31:0] b);
    longint      dvd;
    longint      dvs;
    logic [63:0] res;
    if (f6 == vint_pkg::F6_VDIV || f6 == vint_pkg::F6_VREM) begin
        dvd = $signed(b);
        dvs = $signed(a);
    end else begin
        dvd = longint'({32'd0, b});
        dvs = longint'({32'd0, a});
    end
    if (f6 == vint_pkg::F6_VREM || f6 == vint_pkg::F6_VREMU) begin
        res = dvd % dvs;
    end else begin
        res = dvd / dvs;
    end
    return res[31:0];
endfunction

`endif

//--- tb/tb_vint_lane.sv
// Testbench for the vector integer lane
// Directed and random requests, per-unit expected queues, result checks
`timescale 1ns/1ps

module tb_vint_lane;

    typedef struct packed {
        vint_pkg::vint_data_t data;
        logic [31:0]          due;
    } exp_t;

    localparam logic [5:0] ALU_F6 [13] = '{
        vint_pkg::F6_VADD, vint_pkg::F6_VSUB, vint_pkg::F6_VRSUB, vint_pkg::F6_VAND,
        vint_pkg::F6_VOR, vint_pkg::F6_VXOR, vint_pkg::F6_VSLL_VMUL, vint_pkg::F6_VSRL,
        vint_pkg::F6_VSRA, vint_pkg::F6_VMINU, vint_pkg::F6_VMIN, vint_pkg::F6_VMAXU,
        vint_pkg::F6_VMAX
    };
    localparam logic [5:0] MUL_F6 [4] = '{
        vint_pkg::F6_VSLL_VMUL, vint_pkg::F6_VMULH, vint_pkg::F6_VMULHSU, vint_pkg::F6_VMULHU
    };
    localparam logic [5:0] DIV_F6 [4] = '{
        vint_pkg::F6_VDIVU, vint_pkg::F6_VDIV, vint_pkg::F6_VREMU, vint_pkg::F6_VREM
    };

    logic                clk;
    logic                rst_n;
    vint_pkg::vint_req_t req;
    vint_pkg::vint_res_t alu_res;
    vint_pkg::vint_res_t mul_res;
    vint_pkg::vint_res_t div_res;

    exp_t        exp_q [3][$];
    // Index 3 counts results seen before any request
    int          err_cnt [4];
    logic [31:0] cyc;
    logic [31:0] lcg_state;
    logic        issued_any;

    `include "vint_ref_model.svh"

    vint_lane_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req),
        .alu_res_o (alu_res),
        .mul_res_o (mul_res),
        .div_res_o (div_res)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int latency_of(input int u);
        case (u)
            UNIT_ALU: return 1;
            UNIT_MUL: return 3;
            default:  return 4;
        endcase
    endfunction

    // Drives one request at the next edge and queues its expected result
    task automatic issue(input logic [2:0] f3, input logic [5:0] f6, input logic [31:0] a,
                         input logic [31:0] b, input logic mask);
        int                  u;
        exp_t                e;
        vint_pkg::vint_req_t r;
        @(posedge clk);
        u        = unit_of(f3, f6);
        r.valid  = 1'b1;
        r.funct3 = vint_pkg::vint_funct3_e'(f3);
        r.funct6 = vint_pkg::vint_funct6_e'(f6);
        r.a      = a;
        r.b      = b;
        r.mask   = mask;
        req        <= r;
        issued_any <= 1'b1;
        if (u != UNIT_NONE) begin
            // DUT samples at the following edge
            e.due = cyc + 1 + latency_of(u);
            case (u)
                UNIT_ALU: e.data = ref_alu(f6, a, b);
                UNIT_MUL: e.data = ref_mul(f6, a, b);
                default:  e.data = ref_div(f6, a, b);
            endcase
            if (!mask) begin
                e.data = '0;
            end
            exp_q[u].push_back(e);
        end
    endtask

    task automatic release_req();
        @(posedge clk);
        req.valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size()) != 0 && n < 40) begin
            @(negedge clk);
            n++;
        end
        if ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size()) != 0) begin
            $display("Timeout: results still pending after %0d cycles", n);
            $display("TEST FAIL");
            $finish;
        end
    endtask

    task automatic check_port(input int u, input string name, input vint_pkg::vint_res_t res);
        exp_t head;
        if (res.valid) begin
            assert (exp_q[u].size() != 0) else begin
                $display("ERROR %s valid with no result pending", name);
                err_cnt[u]++;
            end
            if (exp_q[u].size() != 0) begin
                head = exp_q[u].pop_front();
                assert (res.data === head.data) else begin
                    $display("ERROR %s.data expected 0x%h got 0x%h", name, head.data, res.data);
                    err_cnt[u]++;
                end
                assert (cyc == head.due) else begin
                    $display("ERROR %s result came at cycle %0d instead of cycle %0d",
                             name, cyc, head.due);
                    err_cnt[u]++;
                end
            end
        end else if (exp_q[u].size() != 0) begin
            assert (exp_q[u][0].due > cyc) else begin
                $display("ERROR %s gave no result at cycle %0d", name, cyc);
                void'(exp_q[u].pop_front());
                err_cnt[u]++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (!issued_any) begin
                assert (!(alu_res.valid || mul_res.valid || div_res.valid)) else begin
                    $display("ERROR result valid before any request was issued");
                    err_cnt[3]++;
                end
            end
            check_port(UNIT_ALU, "alu_res_o", alu_res);
            check_port(UNIT_MUL, "mul_res_o", mul_res);
            check_port(UNIT_DIV, "div_res_o", div_res);
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int          idx;
        logic        m;
        logic        vx;
        req        = '0;
        rst_n      = 1'b0;
        cyc        = '0;
        lcg_state  = 32'h2a10;
        issued_any = 1'b0;
        err_cnt    = '{0, 0, 0, 0};
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet stretch after reset
        repeat (5) @(posedge clk);

        // ========================================
        // Directed ALU, shifts above 31 and mixed signs
        // ========================================
        for (int i = 0; i < 13; i++) begin
            issue(vint_pkg::OPIVV, ALU_F6[i], 32'h0000_0025, 32'h8765_4321, 1'b1);
            issue(vint_pkg::OPIVX, ALU_F6[i], 32'hffff_fff0, 32'h0000_0005, 1'b1);
            issue(vint_pkg::OPIVV, ALU_F6[i], 32'h0000_0007, 32'hffff_ff00, 1'b1);
        end
        release_req();
        wait_drain();

        // Multiply variants back to back
        for (int i = 0; i < 4; i++) begin
            issue(vint_pkg::OPMVV, MUL_F6[i], 32'hffff_fffd, 32'h0001_0003, 1'b1);
            issue(vint_pkg::OPMVX, MUL_F6[i], 32'h7fff_ffff, 32'h8000_0001, 1'b1);
            issue(vint_pkg::OPMVV, MUL_F6[i], 32'hffff_ffff, 32'hffff_ffff, 1'b1);
        end
        release_req();
        wait_drain();

        // All four sign combinations per divide variant
        for (int i = 0; i < 4; i++) begin
            for (int s = 0; s < 4; s++) begin
                a = (s % 2 != 0) ? 32'hffff_fff9 : 32'd7;
                b = (s / 2 != 0) ? 32'hffff_ff9c : 32'd100;
                issue(vint_pkg::OPMVV, DIV_F6[i], a, b, 1'b1);
            end
            issue(vint_pkg::OPMVX, DIV_F6[i], 32'hffff_ffff, 32'h8000_0000, 1'b1);
        end
        release_req();
        wait_drain();

        // Cleared mask on every unit
        issue(vint_pkg::OPIVV, vint_pkg::F6_VADD, 32'd3, 32'd4, 1'b0);
        issue(vint_pkg::OPMVV, vint_pkg::F6_VSLL_VMUL, 32'd3, 32'd4, 1'b0);
        issue(vint_pkg::OPMVV, vint_pkg::F6_VDIV, 32'd3, 32'd100, 1'b0);
        release_req();
        wait_drain();

        // Unsupported pairs must stay silent for 6 cycles
        issue(vint_pkg::OPIVV, vint_pkg::F6_VDIVU, 32'd3, 32'd100, 1'b1);
        release_req();
        repeat (6) @(posedge clk);
        issue(vint_pkg::OPMVV, vint_pkg::F6_VADD, 32'd3, 32'd100, 1'b1);
        release_req();
        repeat (6) @(posedge clk);
        issue(3'b001, vint_pkg::F6_VADD, 32'd3, 32'd100, 1'b1);
        release_req();
        repeat (6) @(posedge clk);

        // ========================================
        // Random mixed traffic, one request per cycle
        // ========================================
        for (int n = 0; n < 400; n++) begin
            r   = next_rand();
            idx = (r >> 16) % 21;
            vx  = r[3];
            a   = next_rand();
            b   = next_rand();
            m   = (next_rand() >> 29) != 0;
            if (idx < 13) begin
                issue(vx ? vint_pkg::OPIVX : vint_pkg::OPIVV, ALU_F6[idx], a, b, m);
            end else if (idx < 17) begin
                issue(vx ? vint_pkg::OPMVX : vint_pkg::OPMVV, MUL_F6[idx-13], a, b, m);
            end else begin
                // Smaller divisors give nonzero quotients more often
                a = a >> r[8:4];
                if (a == 0) begin
                    a = 32'd1;
                end
                issue(vx ? vint_pkg::OPMVX : vint_pkg::OPMVV, DIV_F6[idx-17], a, b, m);
            end
        end
        release_req();
        wait_drain();
        repeat (2) @(posedge clk);

        $display("Errors: alu %0d, mul %0d, div %0d, idle %0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
        if (err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- logic/vint_lane_top.sv
// Vector integer lane top level
// Decoder feeding the ALU, multiply and divide units on separate result ports
`timescale 1ns/1ps

module vint_lane_top (
    input  logic                clk,
    input  logic                rst_n,
    input  vint_pkg::vint_req_t req_i,
    output vint_pkg::vint_res_t alu_res_o,
    output vint_pkg::vint_res_t mul_res_o,
    output vint_pkg::vint_res_t div_res_o
);

    // Decoded control, shared by all units
    vint_pkg::vint_ctrl_t ctrl;

    vint_decode u_decode (
        .req_i  (req_i),
        .ctrl_o (ctrl)
    );

    // Result one cycle after issue
    vint_simple_alu u_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl_i (ctrl),
        .res_o  (alu_res_o)
    );

    // Result three cycles after issue
    vint_mul_pipe u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl_i (ctrl),
        .res_o  (mul_res_o)
    );

    // Result four cycles after issue
    vint_div_pipe u_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl_i (ctrl),
        .res_o  (div_res_o)
    );

endmodule

//--- logic/vint_div_pipe.sv
// Four-stage divider for signed and unsigned quotient and remainder
// Sign preparation, stage chain and final sign fix with result select
`timescale 1ns/1ps
`include "vint_config.svh"

module vint_div_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vint_pkg::vint_ctrl_t ctrl_i,
    output vint_pkg::vint_res_t  res_o
);

    localparam int W   = `VINT_DATA_W;
    localparam int NST = `VINT_DIV_STAGES;

    logic                      dvd_neg;
    logic                      dvs_neg;
    vint_pkg::vint_div_state_t prep;
    vint_pkg::vint_div_state_t stage_state [NST+1];
    logic [NST:0]              stage_valid;
    vint_pkg::vint_div_state_t last;
    vint_pkg::vint_data_t      quo_fix;
    vint_pkg::vint_data_t      rem_fix;

    // ========================================
    // Sign preparation
    // ========================================
    // Dividend is vs2 (b), divisor is vs1 (a)
    assign dvd_neg = ctrl_i.div_signed & ctrl_i.b[W-1];
    assign dvs_neg = ctrl_i.div_signed & ctrl_i.a[W-1];

    always_comb begin
        prep.quo     = dvd_neg ? -ctrl_i.b : ctrl_i.b;
        prep.prem    = '0;
        prep.divisor = dvs_neg ? -ctrl_i.a : ctrl_i.a;
        // Quotient truncates toward zero, remainder takes the dividend sign
        prep.quo_neg = dvd_neg ^ dvs_neg;
        prep.rem_neg = dvd_neg;
        prep.is_rem  = ctrl_i.div_rem;
        prep.mask    = ctrl_i.mask;
    end

    assign stage_state[0] = prep;
    assign stage_valid[0] = ctrl_i.div_en;

    // ========================================
    // Stage chain
    // ========================================
    for (genvar i = 0; i < NST; i++) begin : g_stage
        vint_div_stage u_stage (
            .clk     (clk),
            .rst_n   (rst_n),
            .valid_i (stage_valid[i]),
            .state_i (stage_state[i]),
            .valid_o (stage_valid[i+1]),
            .state_o (stage_state[i+1])
        );
    end

    // ========================================
    // Sign fix and result select
    // ========================================
    assign last    = stage_state[NST];
    assign quo_fix = last.quo_neg ? -last.quo : last.quo;
    assign rem_fix = last.rem_neg ? -last.prem : last.prem;

    assign res_o.valid = stage_valid[NST];
    assign res_o.data  = !last.mask ? '0 : (last.is_rem ? rem_fix : quo_fix);

endmodule

//--- logic/vint_div_stage.sv
// One registered group of shift-and-subtract division steps
`timescale 1ns/1ps
`include "vint_config.svh"

module vint_div_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid_i,
    input  vint_pkg::vint_div_state_t state_i,
    output logic                      valid_o,
    output vint_pkg::vint_div_state_t state_o
);

    localparam int W     = `VINT_DATA_W;
    localparam int STEPS = `VINT_DATA_W / `VINT_DIV_STAGES;

    vint_pkg::vint_div_state_t state_nxt;

    // Dividend bits shift out of quo into the partial remainder
    // while quotient bits shift in from the bottom
    always_comb begin
        logic [W:0] shifted;
        logic [W:0] diff;
        state_nxt = state_i;
        for (int i = 0; i < STEPS; i++) begin
            shifted = {state_nxt.prem, state_nxt.quo[W-1]};
            diff    = shifted - {1'b0, state_nxt.divisor};
            // Non-negative trial difference sets the quotient bit
            state_nxt.prem = diff[W] ? shifted[W-1:0] : diff[W-1:0];
            state_nxt.quo  = {state_nxt.quo[W-2:0], ~diff[W]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            state_o <= state_nxt;
        end
    end

endmodule

//--- logic/vint_mul_pipe.sv
// Three-stage multiplier built from digit partial products
// Low word, signed high, signed-unsigned high and unsigned high
`timescale 1ns/1ps
`include "vint_config.svh"

module vint_mul_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vint_pkg::vint_ctrl_t ctrl_i,
    output vint_pkg::vint_res_t  res_o
);

    localparam int W     = `VINT_DATA_W;
    localparam int DIG_W = `VINT_DIGIT_W;
    localparam int NDIG  = vint_pkg::MUL_DIGITS;

    logic                     a_neg;
    logic                     b_neg;
    vint_pkg::vint_data_t     a_mag;
    vint_pkg::vint_data_t     b_mag;
    vint_pkg::vint_mul_part_t part_nxt;
    vint_pkg::vint_mul_part_t part_q;
    logic                     part_valid;
    logic [2*W-1:0]           sum_nxt;
    logic [2*W-1:0]           sum_q;
    logic                     sum_neg;
    logic                     sum_upper;
    logic                     sum_mask;
    logic                     sum_valid;
    logic [2*W-1:0]           prod;
    logic                     res_valid;
    vint_pkg::vint_data_t     res_data;

    // ========================================
    // Stage 1 magnitudes and partial products
    // ========================================
    assign a_neg = ctrl_i.mul_a_signed & ctrl_i.a[W-1];
    assign b_neg = ctrl_i.mul_b_signed & ctrl_i.b[W-1];
    assign a_mag = a_neg ? -ctrl_i.a : ctrl_i.a;
    assign b_mag = b_neg ? -ctrl_i.b : ctrl_i.b;

    always_comb begin
        for (int i = 0; i < NDIG; i++) begin
            part_nxt.pp[i] = a_mag * b_mag[i*DIG_W +: DIG_W];
        end
        part_nxt.neg   = a_neg ^ b_neg;
        part_nxt.upper = ctrl_i.mul_upper;
        part_nxt.mask  = ctrl_i.mask;
    end

    // ========================================
    // Stage 2 shifted sum
    // ========================================
    always_comb begin
        sum_nxt = '0;
        for (int i = 0; i < NDIG; i++) begin
            sum_nxt = sum_nxt + ({{(W-DIG_W){1'b0}}, part_q.pp[i]} << (i*DIG_W));
        end
    end

    // ========================================
    // Stage 3 sign fix and half select
    // ========================================
    assign prod = sum_neg ? -sum_q : sum_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            part_valid <= 1'b0;
            sum_valid  <= 1'b0;
            res_valid  <= 1'b0;
        end else begin
            part_valid <= ctrl_i.mul_en;
            sum_valid  <= part_valid;
            res_valid  <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_i.mul_en) begin
            part_q <= part_nxt;
        end
        if (part_valid) begin
            sum_q     <= sum_nxt;
            sum_neg   <= part_q.neg;
            sum_upper <= part_q.upper;
            sum_mask  <= part_q.mask;
        end
        if (sum_valid) begin
            if (!sum_mask) begin
                res_data <= '0;
            end else begin
                res_data <= sum_upper ? prod[2*W-1:W] : prod[W-1:0];
            end
        end
    end

    assign res_o.valid = res_valid;
    assign res_o.data  = res_data;

endmodule

//--- logic/vint_simple_alu.sv
// Single-cycle add, logic, shift and min/max unit with registered result
`timescale 1ns/1ps
`include "vint_config.svh"

module vint_simple_alu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vint_pkg::vint_ctrl_t ctrl_i,
    output vint_pkg::vint_res_t  res_o
);

    localparam int SHAMT_W = $clog2(`VINT_DATA_W);

    vint_pkg::vint_data_t a;
    vint_pkg::vint_data_t b;
    vint_pkg::vint_data_t result;
    logic [SHAMT_W-1:0]   shamt;
    logic                 res_valid;
    vint_pkg::vint_data_t res_data;

    assign a     = ctrl_i.a;
    assign b     = ctrl_i.b;
    // Only the low bits of vs1 count as shift amount
    assign shamt = a[SHAMT_W-1:0];

    // Operand order follows vs2 op vs1
    always_comb begin
        case (ctrl_i.alu_op)
            vint_pkg::ALU_ADD:  result = b + a;
            vint_pkg::ALU_SUB:  result = b - a;
            vint_pkg::ALU_RSUB: result = a - b;
            vint_pkg::ALU_AND:  result = b & a;
            vint_pkg::ALU_OR:   result = b | a;
            vint_pkg::ALU_XOR:  result = b ^ a;
            vint_pkg::ALU_SLL:  result = b << shamt;
            vint_pkg::ALU_SRL:  result = b >> shamt;
            vint_pkg::ALU_SRA:  result = $signed(b) >>> shamt;
            vint_pkg::ALU_MINU: result = (b < a) ? b : a;
            vint_pkg::ALU_MIN:  result = ($signed(b) < $signed(a)) ? b : a;
            vint_pkg::ALU_MAXU: result = (b > a) ? b : a;
            vint_pkg::ALU_MAX:  result = ($signed(b) > $signed(a)) ? b : a;
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= ctrl_i.alu_en;
        end
    end

    // Masked-off elements still return, with zero data
    always_ff @(posedge clk) begin
        if (ctrl_i.alu_en) begin
            res_data <= ctrl_i.mask ? result : '0;
        end
    end

    assign res_o.valid = res_valid;
    assign res_o.data  = res_data;

endmodule

//--- logic/vint_decode.sv
// Opcode decoder that steers a request to the ALU, multiplier or divider
`timescale 1ns/1ps

module vint_decode (
    input  vint_pkg::vint_req_t  req_i,
    output vint_pkg::vint_ctrl_t ctrl_o
);

    logic is_opi;
    logic is_opm;

    assign is_opi = (req_i.funct3 == vint_pkg::OPIVV) || (req_i.funct3 == vint_pkg::OPIVX);
    assign is_opm = (req_i.funct3 == vint_pkg::OPMVV) || (req_i.funct3 == vint_pkg::OPMVX);

    always_comb begin
        ctrl_o      = '0;
        ctrl_o.mask = req_i.mask;
        ctrl_o.a    = req_i.a;
        ctrl_o.b    = req_i.b;

        if (is_opi) begin
            ctrl_o.alu_en = req_i.valid;
            case (req_i.funct6)
                vint_pkg::F6_VADD:      ctrl_o.alu_op = vint_pkg::ALU_ADD;
                vint_pkg::F6_VSUB:      ctrl_o.alu_op = vint_pkg::ALU_SUB;
                vint_pkg::F6_VRSUB:     ctrl_o.alu_op = vint_pkg::ALU_RSUB;
                vint_pkg::F6_VAND:      ctrl_o.alu_op = vint_pkg::ALU_AND;
                vint_pkg::F6_VOR:       ctrl_o.alu_op = vint_pkg::ALU_OR;
                vint_pkg::F6_VXOR:      ctrl_o.alu_op = vint_pkg::ALU_XOR;
                vint_pkg::F6_VSLL_VMUL: ctrl_o.alu_op = vint_pkg::ALU_SLL;
                vint_pkg::F6_VSRL:      ctrl_o.alu_op = vint_pkg::ALU_SRL;
                vint_pkg::F6_VSRA:      ctrl_o.alu_op = vint_pkg::ALU_SRA;
                vint_pkg::F6_VMINU:     ctrl_o.alu_op = vint_pkg::ALU_MINU;
                vint_pkg::F6_VMIN:      ctrl_o.alu_op = vint_pkg::ALU_MIN;
                vint_pkg::F6_VMAXU:     ctrl_o.alu_op = vint_pkg::ALU_MAXU;
                vint_pkg::F6_VMAX:      ctrl_o.alu_op = vint_pkg::ALU_MAX;
                default:                ctrl_o.alu_en = 1'b0;
            endcase
        end else if (is_opm) begin
            case (req_i.funct6)
                // Low product is the same for every signedness
                vint_pkg::F6_VSLL_VMUL: begin
                    ctrl_o.mul_en       = req_i.valid;
                    ctrl_o.mul_a_signed = 1'b1;
                    ctrl_o.mul_b_signed = 1'b1;
                end
                vint_pkg::F6_VMULH: begin
                    ctrl_o.mul_en       = req_i.valid;
                    ctrl_o.mul_a_signed = 1'b1;
                    ctrl_o.mul_b_signed = 1'b1;
                    ctrl_o.mul_upper    = 1'b1;
                end
                // Signed vs2 times unsigned vs1
                vint_pkg::F6_VMULHSU: begin
                    ctrl_o.mul_en       = req_i.valid;
                    ctrl_o.mul_b_signed = 1'b1;
                    ctrl_o.mul_upper    = 1'b1;
                end
                vint_pkg::F6_VMULHU: begin
                    ctrl_o.mul_en    = req_i.valid;
                    ctrl_o.mul_upper = 1'b1;
                end
                vint_pkg::F6_VDIVU: ctrl_o.div_en = req_i.valid;
                vint_pkg::F6_VDIV: begin
                    ctrl_o.div_en     = req_i.valid;
                    ctrl_o.div_signed = 1'b1;
                end
                vint_pkg::F6_VREMU: begin
                    ctrl_o.div_en  = req_i.valid;
                    ctrl_o.div_rem = 1'b1;
                end
                vint_pkg::F6_VREM: begin
                    ctrl_o.div_en     = req_i.valid;
                    ctrl_o.div_signed = 1'b1;
                    ctrl_o.div_rem    = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- logic/vint_pkg.sv
// Shared types of the vector integer lane
// Opcode encodings, request, control, pipeline payload and result structs
`include "vint_config.svh"

package vint_pkg;

    typedef logic [`VINT_DATA_W-1:0] vint_data_t;

    localparam int MUL_DIGITS = `VINT_DATA_W / `VINT_DIGIT_W;
    localparam int MUL_PP_W   = `VINT_DATA_W + `VINT_DIGIT_W;

    // Operand category
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPMVV = 3'b010,
        OPIVX = 3'b100,
        OPMVX = 3'b110
    } vint_funct3_e;

    // Standard vector funct6 codes
    // 100101 is vsll in the OPI category and vmul in the OPM category
    typedef enum logic [5:0] {
        F6_VADD      = 6'b000000,
        F6_VSUB      = 6'b000010,
        F6_VRSUB     = 6'b000011,
        F6_VMINU     = 6'b000100,
        F6_VMIN      = 6'b000101,
        F6_VMAXU     = 6'b000110,
        F6_VMAX      = 6'b000111,
        F6_VAND      = 6'b001001,
        F6_VOR       = 6'b001010,
        F6_VXOR      = 6'b001011,
        F6_VDIVU     = 6'b100000,
        F6_VDIV      = 6'b100001,
        F6_VREMU     = 6'b100010,
        F6_VREM      = 6'b100011,
        F6_VMULHU    = 6'b100100,
        F6_VSLL_VMUL = 6'b100101,
        F6_VMULHSU   = 6'b100110,
        F6_VMULH     = 6'b100111,
        F6_VSRL      = 6'b101000,
        F6_VSRA      = 6'b101001
    } vint_funct6_e;

    // Issue request, a is vs1 or the scalar, b is vs2
    typedef struct packed {
        logic         valid;
        vint_funct3_e funct3;
        vint_funct6_e funct6;
        vint_data_t   a;
        vint_data_t   b;
        logic         mask;
    } vint_req_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_RSUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MINU,
        ALU_MIN,
        ALU_MAXU,
        ALU_MAX
    } vint_alu_op_e;

    typedef struct packed {
        logic         alu_en;
        logic         mul_en;
        logic         div_en;
        vint_alu_op_e alu_op;
        logic         mul_a_signed;
        logic         mul_b_signed;
        logic         mul_upper;
        logic         div_signed;
        logic         div_rem;
        logic         mask;
        vint_data_t   a;
        vint_data_t   b;
    } vint_ctrl_t;

    // Multiplier payload after the partial product stage
    typedef struct packed {
        logic [MUL_DIGITS-1:0][MUL_PP_W-1:0] pp;
        logic                                neg;
        logic                                upper;
        logic                                mask;
    } vint_mul_part_t;

    // Divider payload between stages
    typedef struct packed {
        vint_data_t quo;
        vint_data_t prem;
        vint_data_t divisor;
        logic       quo_neg;
        logic       rem_neg;
        logic       is_rem;
        logic       mask;
    } vint_div_state_t;

    typedef struct packed {
        logic       valid;
        vint_data_t data;
    } vint_res_t;

endpackage

//--- logic/vint_config.svh
// Width and depth macros for the vector integer lane
`ifndef VINT_CONFIG_SVH
`define VINT_CONFIG_SVH

// Element width
`define VINT_DATA_W 32

// Multiplier digit width, one partial product per digit
`define VINT_DIGIT_W 8

// Divider stages, each resolving VINT_DATA_W / VINT_DIV_STAGES quotient bits
`define VINT_DIV_STAGES 4

`endif
